/* logic/dccm_pkg.sv */
// shared widths, bank layout and packed structs for the DCCM control block and its testbench
package dccm_pkg;

   // bank word layout
   parameter int dccm_data_width  = 32;                          // data bits per bank word
   parameter int dccm_ecc_width   = 7;                           // ecc bits per bank word
   parameter int dccm_fdata_width = dccm_data_width + dccm_ecc_width;
   parameter int dccm_byte_width  = dccm_data_width / 8;         // bytes per bank word
   parameter int dccm_width_bits  = $clog2(dccm_byte_width);     // byte offset bits
   parameter int dccm_bank_bits   = 1;                           // bank select, above the offset

   // pipe packet, one per stage
   typedef struct packed {
      logic valid;
      logic load;
      logic store;
      logic by;                                                  // byte access
      logic half;                                                // halfword access
      logic word;
      logic dword;
      logic dma;                                                 // access issued by dma
   } lsu_pkt_t;

   // stored word as it sits in a bank
   typedef struct packed {
      logic [dccm_ecc_width-1:0]  ecc;
      logic [dccm_data_width-1:0] data;
   } dccm_word_t;

   // store buffer forward toward a load in M, hi bank in the upper half
   typedef struct packed {
      logic [2*dccm_byte_width-1:0] byteen;
      logic [2*dccm_data_width-1:0] data;
   } stbuf_fwd_t;

   // correction waiting for the write port
   typedef struct packed {
      logic       flag_lo;
      logic       flag_hi;
      dccm_word_t word_lo;                                       // corrected lo bank word
      dccm_word_t word_hi;                                       // corrected hi bank word
   } scrub_req_t;

endpackage

/* logic/dccm_port_arb.sv */
// DCCM port control: read enable, store buffer commit and write port select toward the banks
`timescale 1ns/1ps

module dccm_port_arb #(
   parameter int DCCM_BITS = 16
) (
   input  logic                       clk,
   input  logic                       reset,

   input  dccm_pkg::lsu_pkt_t         lsu_pkt_d,
   input  logic                       addr_in_dccm_d,
   input  logic [DCCM_BITS-1:0]       lsu_addr_d,
   input  logic [DCCM_BITS-1:0]       end_addr_d,         // last byte of the access

   input  logic                       stbuf_reqvld_any,   // held until commit
   input  logic [DCCM_BITS-1:0]       stbuf_addr_any,
   input  dccm_pkg::dccm_word_t       stbuf_word_any,

   input  logic                       dma_dccm_wen,
   input  dccm_pkg::dccm_word_t       dma_word_lo,
   input  dccm_pkg::dccm_word_t       dma_word_hi,

   input  dccm_pkg::scrub_req_t       scrub_req,
   input  logic [DCCM_BITS-1:0]       scrub_addr_lo,
   input  logic [DCCM_BITS-1:0]       scrub_addr_hi,

   output logic                       dccm_rden,
   output logic [DCCM_BITS-1:0]       dccm_rd_addr_lo,
   output logic [DCCM_BITS-1:0]       dccm_rd_addr_hi,
   output logic                       dccm_wren,
   output logic [DCCM_BITS-1:0]       dccm_wr_addr_lo,
   output logic [DCCM_BITS-1:0]       dccm_wr_addr_hi,
   output dccm_pkg::dccm_word_t       dccm_wr_data_lo,
   output dccm_pkg::dccm_word_t       dccm_wr_data_hi,
   output logic                       lsu_stbuf_commit_any // one cycle ack to the store buffer
);

   logic                 scrub_pending;
   logic                 word_store_aligned;
   logic                 bank_free;
   logic [DCCM_BITS-1:0] scrub_addr;
   dccm_pkg::dccm_word_t scrub_word;

   assign scrub_pending = scrub_req.flag_lo | scrub_req.flag_hi;

   // full aligned word/dword stores rewrite the ecc completely, so no read
   assign word_store_aligned = (lsu_pkt_d.word | lsu_pkt_d.dword) &
                               (lsu_addr_d[dccm_pkg::dccm_width_bits-1:0] == '0);

   assign dccm_rden = lsu_pkt_d.valid & addr_in_dccm_d &
                      (lsu_pkt_d.load | (lsu_pkt_d.store & ~word_store_aligned));
   assign dccm_rd_addr_lo = lsu_addr_d;
   assign dccm_rd_addr_hi = end_addr_d;

   // store buffer may share the cycle with a read in the other bank
   assign bank_free =
      (stbuf_addr_any[dccm_pkg::dccm_width_bits +: dccm_pkg::dccm_bank_bits] !=
       lsu_addr_d[dccm_pkg::dccm_width_bits +: dccm_pkg::dccm_bank_bits]) &&
      (stbuf_addr_any[dccm_pkg::dccm_width_bits +: dccm_pkg::dccm_bank_bits] !=
       end_addr_d[dccm_pkg::dccm_width_bits +: dccm_pkg::dccm_bank_bits]);

   assign lsu_stbuf_commit_any = stbuf_reqvld_any & ~dma_dccm_wen & ~scrub_pending &
                                 (~dccm_rden | bank_free);

   assign dccm_wren = scrub_pending | dma_dccm_wen | lsu_stbuf_commit_any;

   // lo wins when both banks need correcting
   assign scrub_addr = scrub_req.flag_lo ? scrub_addr_lo : scrub_addr_hi;
   assign scrub_word = scrub_req.flag_lo ? scrub_req.word_lo : scrub_req.word_hi;

   always_comb begin
      if (scrub_pending) begin
         dccm_wr_addr_lo = scrub_addr;
         dccm_wr_addr_hi = scrub_addr;
         dccm_wr_data_lo = scrub_word;
         dccm_wr_data_hi = scrub_word;
      end else if (dma_dccm_wen) begin
         dccm_wr_addr_lo = lsu_addr_d;
         dccm_wr_addr_hi = end_addr_d;
         dccm_wr_data_lo = dma_word_lo;
         dccm_wr_data_hi = dma_word_hi;
      end else begin
         dccm_wr_addr_lo = stbuf_addr_any;   // store buffer words are already aligned
         dccm_wr_addr_hi = stbuf_addr_any;
         dccm_wr_data_lo = stbuf_word_any;
         dccm_wr_data_hi = stbuf_word_any;
      end
   end

   // a correction from the scrub unit must never share the port with dma or a commit
   assert property (@(posedge clk) disable iff (reset)
      $onehot0({scrub_pending, dma_dccm_wen, lsu_stbuf_commit_any}))
      else $error("more than one dccm write source in a cycle");

endmodule

/* logic/dccm_load_path.sv */
// DCCM load return path: registers bank data into R, merges forwarded bytes, right-justifies
`timescale 1ns/1ps

module dccm_load_path #(
   parameter int DCCM_BITS = 16
) (
   input  logic                 clk,
   input  logic                 reset,

   input  logic                 dccm_rden,          // read issued in D
   input  dccm_pkg::dccm_word_t dccm_rd_data_lo,    // memory returns in M
   input  dccm_pkg::dccm_word_t dccm_rd_data_hi,
   input  dccm_pkg::stbuf_fwd_t stbuf_fwd_m,

   input  logic [DCCM_BITS-1:0] lsu_addr_r,
   input  dccm_pkg::dccm_word_t sec_word_lo_r,      // checker output for R
   input  dccm_pkg::dccm_word_t sec_word_hi_r,

   output dccm_pkg::dccm_word_t dccm_rdata_lo_r,
   output dccm_pkg::dccm_word_t dccm_rdata_hi_r,
   output logic [dccm_pkg::dccm_data_width-1:0] lsu_ld_data_r,
   output logic [dccm_pkg::dccm_data_width-1:0] lsu_ld_data_corr_r
);

   localparam int dw = 2 * dccm_pkg::dccm_data_width;   // both banks side by side

   logic                 rden_m;
   logic                 rden_r;
   dccm_pkg::stbuf_fwd_t stbuf_fwd_r;
   logic [dw-1:0]        ld_raw_r;
   logic [dw-1:0]        ld_corr_r;
   logic [dw-1:0]        ld_raw_shift;
   logic [dw-1:0]        ld_corr_shift;

   // forwarded bytes override bank bytes one at a time
   function automatic logic [dw-1:0] fwd_merge(dccm_pkg::stbuf_fwd_t fwd, logic [dw-1:0] bank);
      logic [dw-1:0] merged;
      for (int i = 0; i < 2 * dccm_pkg::dccm_byte_width; i++) begin
         merged[8*i +: 8] = fwd.byteen[i] ? fwd.data[8*i +: 8] : bank[8*i +: 8];
      end
      return merged;
   endfunction

   always_ff @(posedge clk) begin
      if (reset) begin
         rden_m <= 1'b0;
         rden_r <= 1'b0;
      end else begin
         rden_m <= dccm_rden;
         rden_r <= rden_m;
      end
   end

   // bank words only move when a read is in M
   always_ff @(posedge clk) begin
      if (rden_m) begin
         dccm_rdata_lo_r <= dccm_rd_data_lo;
         dccm_rdata_hi_r <= dccm_rd_data_hi;
      end
   end

   always_ff @(posedge clk) begin
      stbuf_fwd_r <= stbuf_fwd_m;                       // loads every cycle
   end

   assign ld_raw_r  = fwd_merge(stbuf_fwd_r, {dccm_rdata_hi_r.data, dccm_rdata_lo_r.data});
   assign ld_corr_r = fwd_merge(stbuf_fwd_r, {sec_word_hi_r.data, sec_word_lo_r.data});

   // byte offset moves the first loaded byte down to bit 0
   assign ld_raw_shift  = ld_raw_r  >> {lsu_addr_r[dccm_pkg::dccm_width_bits-1:0], 3'b000};
   assign ld_corr_shift = ld_corr_r >> {lsu_addr_r[dccm_pkg::dccm_width_bits-1:0], 3'b000};

   assign lsu_ld_data_r      = ld_raw_shift[dccm_pkg::dccm_data_width-1:0];
   assign lsu_ld_data_corr_r = ld_corr_shift[dccm_pkg::dccm_data_width-1:0];

   assert property (@(posedge clk) disable iff (reset) rden_r |-> $past(rden_m))
      else $error("load reached R without passing M");

endmodule

/* logic/dccm_ecc_scrub.sv */
// DCCM ECC scrub: flags single-bit errors on loads in R and holds the correction for writeback
`timescale 1ns/1ps

module dccm_ecc_scrub #(
   parameter int DCCM_BITS = 16
) (
   input  logic                 clk,
   input  logic                 reset,

   input  dccm_pkg::lsu_pkt_t   lsu_pkt_r,
   input  logic [DCCM_BITS-1:0] lsu_addr_r,
   input  logic [DCCM_BITS-1:0] end_addr_r,
   input  logic                 lsu_commit_r,
   input  logic                 lsu_raw_fwd_lo_r,        // bank fully forwarded, memory unused
   input  logic                 lsu_raw_fwd_hi_r,

   input  logic                 single_ecc_error_lo_r,
   input  logic                 single_ecc_error_hi_r,
   input  logic                 lsu_double_ecc_error_r,
   input  dccm_pkg::dccm_word_t sec_word_lo_r,
   input  dccm_pkg::dccm_word_t sec_word_hi_r,

   output logic                 ld_single_ecc_error_r,
   output dccm_pkg::scrub_req_t scrub_req,
   output logic [DCCM_BITS-1:0] scrub_addr_lo,
   output logic [DCCM_BITS-1:0] scrub_addr_hi
);

   logic                 err_lo_r;
   logic                 err_hi_r;
   logic                 keep;
   logic                 flag_lo;
   logic                 flag_hi;
   dccm_pkg::dccm_word_t corr_lo;
   dccm_pkg::dccm_word_t corr_hi;

   assign err_lo_r = lsu_pkt_r.load & single_ecc_error_lo_r & ~lsu_raw_fwd_lo_r;
   assign err_hi_r = lsu_pkt_r.load & single_ecc_error_hi_r & ~lsu_raw_fwd_hi_r;

   assign ld_single_ecc_error_r = (err_lo_r | err_hi_r) & ~lsu_double_ecc_error_r;

   // only committed or dma loads write their correction back
   assign keep = (lsu_commit_r | lsu_pkt_r.dma) & ~lsu_double_ecc_error_r;

   always_ff @(posedge clk) begin
      if (reset) begin
         flag_lo <= 1'b0;
         flag_hi <= 1'b0;
      end else begin
         flag_lo <= err_lo_r & keep;
         flag_hi <= err_hi_r & keep;
      end
   end

   always_ff @(posedge clk) begin
      if (ld_single_ecc_error_r) begin
         scrub_addr_lo <= lsu_addr_r;
         scrub_addr_hi <= end_addr_r;
         corr_lo       <= sec_word_lo_r;
         corr_hi       <= sec_word_hi_r;
      end
   end

   assign scrub_req = '{flag_lo: flag_lo, flag_hi: flag_hi, word_lo: corr_lo, word_hi: corr_hi};

   assert property (@(posedge clk) disable iff (reset)
      (scrub_req.flag_lo || scrub_req.flag_hi) |-> $past(lsu_commit_r || lsu_pkt_r.dma))
      else $error("ecc correction without commit or dma");

endmodule

/* logic/dccm_ctl_top.sv */
// DCCM control top level: wires port control, load return path and ECC scrub together
`timescale 1ns/1ps

module dccm_ctl_top #(
   parameter int DCCM_BITS = 16                          // byte address width inside the DCCM
) (
   input  logic                 clk,
   input  logic                 reset,

   input  dccm_pkg::lsu_pkt_t   lsu_pkt_d,
   input  logic                 addr_in_dccm_d,
   input  logic [DCCM_BITS-1:0] lsu_addr_d,
   input  logic [DCCM_BITS-1:0] end_addr_d,

   input  dccm_pkg::dccm_word_t dccm_rd_data_lo,
   input  dccm_pkg::dccm_word_t dccm_rd_data_hi,
   input  dccm_pkg::stbuf_fwd_t stbuf_fwd_m,

   input  dccm_pkg::lsu_pkt_t   lsu_pkt_r,
   input  logic [DCCM_BITS-1:0] lsu_addr_r,
   input  logic [DCCM_BITS-1:0] end_addr_r,
   input  logic                 lsu_commit_r,
   input  logic                 lsu_raw_fwd_lo_r,
   input  logic                 lsu_raw_fwd_hi_r,
   input  logic                 single_ecc_error_lo_r,
   input  logic                 single_ecc_error_hi_r,
   input  logic                 lsu_double_ecc_error_r,
   input  dccm_pkg::dccm_word_t sec_word_lo_r,
   input  dccm_pkg::dccm_word_t sec_word_hi_r,

   input  logic                 stbuf_reqvld_any,
   input  logic [DCCM_BITS-1:0] stbuf_addr_any,
   input  dccm_pkg::dccm_word_t stbuf_word_any,

   input  logic                 dma_dccm_wen,
   input  dccm_pkg::dccm_word_t dma_word_lo,
   input  dccm_pkg::dccm_word_t dma_word_hi,

   output logic                 dccm_rden,
   output logic [DCCM_BITS-1:0] dccm_rd_addr_lo,
   output logic [DCCM_BITS-1:0] dccm_rd_addr_hi,
   output logic                 dccm_wren,
   output logic [DCCM_BITS-1:0] dccm_wr_addr_lo,
   output logic [DCCM_BITS-1:0] dccm_wr_addr_hi,
   output dccm_pkg::dccm_word_t dccm_wr_data_lo,
   output dccm_pkg::dccm_word_t dccm_wr_data_hi,
   output logic                 lsu_stbuf_commit_any,

   output dccm_pkg::dccm_word_t dccm_rdata_lo_r,
   output dccm_pkg::dccm_word_t dccm_rdata_hi_r,
   output logic [dccm_pkg::dccm_data_width-1:0] lsu_ld_data_r,
   output logic [dccm_pkg::dccm_data_width-1:0] lsu_ld_data_corr_r,
   output logic                 ld_single_ecc_error_r
);

   dccm_pkg::scrub_req_t scrub_req;                      // correction pending for the port
   logic [DCCM_BITS-1:0] scrub_addr_lo;
   logic [DCCM_BITS-1:0] scrub_addr_hi;

   dccm_port_arb #(.DCCM_BITS(DCCM_BITS)) dccm_port_arb_inst (.*);

   dccm_load_path #(.DCCM_BITS(DCCM_BITS)) dccm_load_path_inst (.*);

   dccm_ecc_scrub #(.DCCM_BITS(DCCM_BITS)) dccm_ecc_scrub_inst (.*);

endmodule

/* sim/dccm_ctl_tb.sv */
// testbench applying a table of stimulus and expected values to the DCCM control block per cycle
`timescale 1ns/1ps

module dccm_ctl_tb;

   typedef struct packed {
      int                   test;                               // owning test number
      dccm_pkg::lsu_pkt_t   pkt_d, pkt_r;
      logic                 in_dccm, commit, raw_lo, raw_hi, serr_lo, serr_hi, derr;
      logic                 sb_req, dma_wen;
      logic [15:0]          addr_d, end_d, addr_r, end_r, sb_addr;
      dccm_pkg::dccm_word_t rd_lo, rd_hi, sec_lo, sec_hi, sb_word, dma_lo, dma_hi;
      dccm_pkg::stbuf_fwd_t fwd;
      logic                 rden, wren, sb_commit, ld_err;      // checked on every row
      logic                 chk_wr, chk_ld;
      logic [15:0]          wr_addr_lo, wr_addr_hi;
      dccm_pkg::dccm_word_t wr_lo, wr_hi;
      logic [31:0]          ld_data, ld_corr;
      dccm_pkg::dccm_word_t rdata_lo, rdata_hi;                 // bank words held in R
   } row_t;

   // packet bits: valid load store by half word dword dma
   localparam dccm_pkg::lsu_pkt_t ld_word  = 8'b1100_0100;
   localparam dccm_pkg::lsu_pkt_t st_byte  = 8'b1011_0000;
   localparam dccm_pkg::lsu_pkt_t st_word  = 8'b1010_0100;
   localparam dccm_pkg::lsu_pkt_t dma_word = 8'b1010_0101;

   logic        clk = 1'b0;
   logic        reset;
   row_t        cur;                                            // row on the DUT inputs
   row_t        tbl [0:63];
   string       names [0:7];
   int          n_rows, limit, cycles, errors, test_err, tests_run, tests_failed;
   logic [31:0] seed;

   logic                 dccm_rden, dccm_wren, lsu_stbuf_commit_any, ld_single_ecc_error_r;
   logic [15:0]          dccm_rd_addr_lo, dccm_rd_addr_hi, dccm_wr_addr_lo, dccm_wr_addr_hi;
   dccm_pkg::dccm_word_t dccm_wr_data_lo, dccm_wr_data_hi, dccm_rdata_lo_r, dccm_rdata_hi_r;
   logic [31:0]          lsu_ld_data_r, lsu_ld_data_corr_r;

   dccm_ctl_top #(.DCCM_BITS(16)) dccm_ctl_top_inst (
      .*,
      .lsu_pkt_d(cur.pkt_d),                .addr_in_dccm_d(cur.in_dccm),
      .lsu_addr_d(cur.addr_d),              .end_addr_d(cur.end_d),
      .dccm_rd_data_lo(cur.rd_lo),          .dccm_rd_data_hi(cur.rd_hi),
      .stbuf_fwd_m(cur.fwd),                .lsu_pkt_r(cur.pkt_r),
      .lsu_addr_r(cur.addr_r),              .end_addr_r(cur.end_r),
      .lsu_commit_r(cur.commit),            .lsu_raw_fwd_lo_r(cur.raw_lo),
      .lsu_raw_fwd_hi_r(cur.raw_hi),        .single_ecc_error_lo_r(cur.serr_lo),
      .single_ecc_error_hi_r(cur.serr_hi),  .lsu_double_ecc_error_r(cur.derr),
      .sec_word_lo_r(cur.sec_lo),           .sec_word_hi_r(cur.sec_hi),
      .stbuf_reqvld_any(cur.sb_req),        .stbuf_addr_any(cur.sb_addr),
      .stbuf_word_any(cur.sb_word),         .dma_dccm_wen(cur.dma_wen),
      .dma_word_lo(cur.dma_lo),             .dma_word_hi(cur.dma_hi)
   );

   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > limit) begin
         $display("timeout: the table did not finish within %0d cycles", limit);
         $display("TEST FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] lcg();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed;
   endfunction

   function automatic dccm_pkg::dccm_word_t rand_word();
      dccm_pkg::dccm_word_t w;
      logic [31:0]          e;
      e = lcg();
      w.ecc = e[6:0];
      w.data = lcg();
      return w;
   endfunction

   // pick the forwarded or bank byte, then take four bytes starting at the offset
   function automatic logic [31:0] expect_load(logic [63:0] bank, dccm_pkg::stbuf_fwd_t fwd,
                                               logic [1:0] off);
      logic [7:0]  bytes [0:7];
      logic [31:0] res;
      for (int b = 0; b < 8; b++) begin
         bytes[b] = fwd.byteen[b] ? fwd.data[8*b +: 8] : bank[8*b +: 8];
      end
      for (int k = 0; k < 4; k++) begin
         res[8*k +: 8] = bytes[int'(off) + k];
      end
      return res;
   endfunction

   task automatic add_rows(input int test, input int count, output int base);
      base = n_rows;
      for (int i = 0; i < count; i++) begin
         tbl[n_rows] = '0;
         tbl[n_rows].test = test;
         n_rows++;
      end
   endtask

   task automatic d_access(input int i, input dccm_pkg::lsu_pkt_t p, input logic [15:0] a,
                           input logic [15:0] e);
      tbl[i].pkt_d = p;
      tbl[i].in_dccm = 1'b1;
      tbl[i].addr_d = a;
      tbl[i].end_d = e;
   endtask

   task automatic r_load(input int i, input logic [15:0] a, input logic commit);
      tbl[i].pkt_r = ld_word;
      tbl[i].addr_r = a;
      tbl[i].end_r = a + 16'd3;
      tbl[i].commit = commit;
      tbl[i].sec_lo = rand_word();
      tbl[i].sec_hi = rand_word();
   endtask

   task automatic sb_request(input int i, input logic [15:0] a);
      tbl[i].sb_req = 1'b1;
      tbl[i].sb_addr = a;
      tbl[i].sb_word = rand_word();
   endtask

   task automatic expect_write(input int i, input logic [15:0] al, input logic [15:0] ah,
                               input dccm_pkg::dccm_word_t lo, input dccm_pkg::dccm_word_t hi);
      tbl[i].wren = 1'b1;
      tbl[i].chk_wr = 1'b1;
      tbl[i].wr_addr_lo = al;
      tbl[i].wr_addr_hi = ah;
      tbl[i].wr_lo = lo;
      tbl[i].wr_hi = hi;
   endtask

   task automatic build_table();
      int          b;
      logic [31:0] r;
      logic [31:0] e;
      names[1] = "read enable";
      add_rows(1, 4, b);
      d_access(b + 1, ld_word, 16'h0104, 16'h0107);
      tbl[b + 1].rden = 1'b1;
      d_access(b + 2, st_byte, 16'h0203, 16'h0203);                // partial store reads first
      tbl[b + 2].rden = 1'b1;
      d_access(b + 3, st_word, 16'h0200, 16'h0203);
      names[2] = "load data and forward merge";
      add_rows(2, 6, b);
      for (int i = 0; i < 4; i++) begin
         r = lcg();
         e = lcg();
         d_access(b + i, ld_word, r[15:0], r[15:0] + 16'd3);
         tbl[b + i].rden = 1'b1;
         tbl[b + i + 1].rd_lo = rand_word();                      // memory answers in M
         tbl[b + i + 1].rd_hi = rand_word();
         tbl[b + i + 1].fwd.byteen = e[7:0];
         tbl[b + i + 1].fwd.data = {lcg(), lcg()};
         r_load(b + i + 2, r[15:0], 1'b0);
         tbl[b + i + 2].chk_ld = 1'b1;
         tbl[b + i + 2].rdata_lo = tbl[b + i + 1].rd_lo;
         tbl[b + i + 2].rdata_hi = tbl[b + i + 1].rd_hi;
         tbl[b + i + 2].ld_data = expect_load({tbl[b + i + 1].rd_hi.data,
            tbl[b + i + 1].rd_lo.data}, tbl[b + i + 1].fwd, r[1:0]);
         tbl[b + i + 2].ld_corr = expect_load({tbl[b + i + 2].sec_hi.data,
            tbl[b + i + 2].sec_lo.data}, tbl[b + i + 1].fwd, r[1:0]);
      end
      names[3] = "write priority";
      add_rows(3, 5, b);
      d_access(b, dma_word, 16'h0310, 16'h0314);
      tbl[b].dma_wen = 1'b1;
      tbl[b].dma_lo = rand_word();
      tbl[b].dma_hi = rand_word();
      sb_request(b, 16'h0120);                                     // loses to dma
      expect_write(b, 16'h0310, 16'h0314, tbl[b].dma_lo, tbl[b].dma_hi);
      sb_request(b + 1, 16'h0120);
      tbl[b + 1].sb_commit = 1'b1;
      expect_write(b + 1, 16'h0120, 16'h0120, tbl[b + 1].sb_word, tbl[b + 1].sb_word);
      for (int i = 2; i < 5; i++) begin
         sb_request(b + i, 16'h0124);                              // hi bank
         tbl[b + i].rden = 1'b1;
      end
      d_access(b + 2, ld_word, 16'h0400, 16'h0403);
      tbl[b + 2].sb_commit = 1'b1;
      expect_write(b + 2, 16'h0124, 16'h0124, tbl[b + 2].sb_word, tbl[b + 2].sb_word);
      d_access(b + 3, ld_word, 16'h0404, 16'h0407);
      d_access(b + 4, ld_word, 16'h0402, 16'h0405);                // spans both banks
      names[4] = "ecc correction writeback";
      add_rows(4, 3, b);
      r_load(b, 16'h0508, 1'b1);
      tbl[b].serr_lo = 1'b1;
      tbl[b].ld_err = 1'b1;
      sb_request(b + 1, 16'h0100);
      expect_write(b + 1, 16'h0508, 16'h0508, tbl[b].sec_lo, tbl[b].sec_lo);
      names[5] = "no correction";
      add_rows(5, 6, b);
      r_load(b, 16'h0600, 1'b0);
      tbl[b].serr_lo = 1'b1;
      tbl[b].ld_err = 1'b1;
      r_load(b + 2, 16'h0610, 1'b1);
      tbl[b + 2].serr_lo = 1'b1;
      tbl[b + 2].derr = 1'b1;
      r_load(b + 4, 16'h0624, 1'b1);
      tbl[b + 4].serr_hi = 1'b1;
      tbl[b + 4].raw_hi = 1'b1;
   endtask

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp)
         else begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            test_err++;
            errors++;
         end
   endtask

   task automatic check_row(input row_t r);
      check_val("dccm_rden", 64'(dccm_rden), 64'(r.rden));
      check_val("dccm_wren", 64'(dccm_wren), 64'(r.wren));
      check_val("lsu_stbuf_commit_any", 64'(lsu_stbuf_commit_any), 64'(r.sb_commit));
      check_val("ld_single_ecc_error_r", 64'(ld_single_ecc_error_r), 64'(r.ld_err));
      if (r.rden) begin
         check_val("dccm_rd_addr_lo", 64'(dccm_rd_addr_lo), 64'(r.addr_d));
         check_val("dccm_rd_addr_hi", 64'(dccm_rd_addr_hi), 64'(r.end_d));
      end
      if (r.chk_wr) begin
         check_val("dccm_wr_addr_lo", 64'(dccm_wr_addr_lo), 64'(r.wr_addr_lo));
         check_val("dccm_wr_addr_hi", 64'(dccm_wr_addr_hi), 64'(r.wr_addr_hi));
         check_val("dccm_wr_data_lo", 64'(dccm_wr_data_lo), 64'(r.wr_lo));
         check_val("dccm_wr_data_hi", 64'(dccm_wr_data_hi), 64'(r.wr_hi));
      end
      if (r.chk_ld) begin
         check_val("dccm_rdata_lo_r", 64'(dccm_rdata_lo_r), 64'(r.rdata_lo));
         check_val("dccm_rdata_hi_r", 64'(dccm_rdata_hi_r), 64'(r.rdata_hi));
         check_val("lsu_ld_data_r", 64'(lsu_ld_data_r), 64'(r.ld_data));
         check_val("lsu_ld_data_corr_r", 64'(lsu_ld_data_corr_r), 64'(r.ld_corr));
      end
   endtask

   task automatic report_test(input int t);
      tests_run++;
      if (test_err == 0) begin
         $display("test %0d, %s: pass", t, names[t]);
      end else begin
         tests_failed++;
         $display("test %0d, %s: %0d errors", t, names[t], test_err);
      end
      test_err = 0;
   endtask

   initial begin
      seed = 32'h28e0;
      cur = '0;
      reset = 1'b1;
      build_table();
      limit = n_rows + 16 + 20;                                    // rows, reset and slack
      repeat (16) @(posedge clk);
      #1;
      reset = 1'b0;
      for (int i = 0; i < n_rows; i++) begin
         cur = tbl[i];
         #98;                                                      // just before the next edge
         check_row(tbl[i]);
         if (i == n_rows - 1 || tbl[i + 1].test != tbl[i].test) begin
            report_test(tbl[i].test);
         end
         @(posedge clk);
         #1;
      end
      $display("%0d tests, %0d passed, %0d failed, %0d errors", tests_run,
               tests_run - tests_failed, tests_failed, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* vlog.f */
logic/dccm_pkg.sv
logic/dccm_port_arb.sv
logic/dccm_load_path.sv
logic/dccm_ecc_scrub.sv
logic/dccm_ctl_top.sv
sim/dccm_ctl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile with Verilator, run, and pass only when the testbench reports success

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module dccm_ctl_tb -Mdir obj_dir \
   || { echo "verilator build failed"; exit 1; }

sim_out=$(./obj_dir/Vdccm_ctl_tb)
echo "$sim_out"
echo "$sim_out" | grep -qx "TEST OK" && exit 0 || exit 1
